//--- src/axi_bridge_pkg.sv
// Shared definitions for the AXI4 burst master bridge
// Bus widths, response codes, command opcodes and arbiter states

package axi_bridge_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;

  // AXLEN field
  localparam int LEN_W   = 8;

  // User word count, 1 to 256
  localparam int COUNT_W = 9;

  // Address bits below one data word
  localparam int BYTE_OFF_W = $clog2(DATA_W / 8);

  // --------------------------------------------------
  // AXI response codes
  // --------------------------------------------------
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_EXOKAY = 2'b01;
  localparam resp_t RESP_SLVERR = 2'b10;
  localparam resp_t RESP_DECERR = 2'b11;

  // SLVERR and DECERR both carry the upper bit
  function automatic logic resp_is_err(resp_t resp);
    return resp[1];
  endfunction

  // --------------------------------------------------
  // Command and arbiter encodings
  // --------------------------------------------------
  // Engine that holds the grant
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

  typedef enum logic [1:0] {
    ARB_IDLE = 2'b00,
    ARB_BUSY = 2'b01,
    ARB_DONE = 2'b10
  } arb_state_e;

endpackage

//--- src/burst_fifo.sv
// Circular data FIFO used on both bridge data paths
// Memory held inline, head-of-queue word shown combinationally,
// empty and almost-full flags registered from the next count

`timescale 1ns/1ps

module burst_fifo
  import axi_bridge_pkg::*;
#(
  parameter int FIFO_AW         = 4,
  parameter int ALMOST_FULL_GAP = 3
) (
  input  logic              ACLK,
  input  logic              aresetn_rrr,
  input  logic              enq,
  input  logic [DATA_W-1:0] data_in,
  input  logic              deq,
  output logic [DATA_W-1:0] data_out,
  output logic              empty,
  output logic              almost_full
);

  localparam int DEPTH = 2 ** FIFO_AW;
  localparam int CNT_W = FIFO_AW + 1;

  // Occupancy levels in count width
  localparam logic [CNT_W-1:0] FULL_LEVEL = CNT_W'(DEPTH);
  localparam logic [CNT_W-1:0] AF_LEVEL   = CNT_W'(DEPTH - ALMOST_FULL_GAP);

  logic [DATA_W-1:0]  mem [DEPTH];
  logic [FIFO_AW-1:0] head;
  logic [FIFO_AW-1:0] tail;
  logic [CNT_W-1:0]   count;
  logic [CNT_W-1:0]   count_nxt;
  logic               do_enq;
  logic               do_deq;

  // Full blocks the push, empty blocks the pop
  // With both requests in the middle range, count holds
  assign do_enq = enq && (count != FULL_LEVEL);
  assign do_deq = deq && (count != '0);

  always_comb begin
    count_nxt = count;
    if (do_enq && !do_deq) begin
      count_nxt = count + 1'b1;
    end else if (do_deq && !do_enq) begin
      count_nxt = count - 1'b1;
    end
  end

  // Storage, written at the head
  always_ff @(posedge ACLK) begin
    if (do_enq) begin
      mem[head] <= data_in;
    end
  end

  // Pointers wrap naturally on the power-of-two depth
  always_ff @(posedge ACLK) begin
    if (!aresetn_rrr) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      empty       <= 1'b1;
      almost_full <= 1'b0;
    end else begin
      if (do_enq) begin
        head <= head + 1'b1;
      end
      if (do_deq) begin
        tail <= tail + 1'b1;
      end
      count       <= count_nxt;
      empty       <= (count_nxt == '0);
      almost_full <= (count_nxt >= AF_LEVEL);
    end
  end

  // Oldest word
  assign data_out = mem[tail];

endmodule

//--- src/command_arbiter.sv
// Command arbiter for the burst bridge
// Latches and word-aligns one user command, grants the read or write
// engine, pulses user_ready on completion and keeps the sticky error

`timescale 1ns/1ps

module command_arbiter
  import axi_bridge_pkg::*;
(
  input  logic               ACLK,
  input  logic               aresetn_rrr,
  input  logic [ADDR_W-1:0]  user_addr,
  input  logic [COUNT_W-1:0] user_word_size,
  input  logic               user_read_enable,
  input  logic               user_write_enable,
  input  logic               rd_done,
  input  logic               wr_done,
  input  logic               rd_resp_err,
  input  logic               wr_resp_err,
  output logic               user_ready,
  output logic               rd_start,
  output logic               wr_start,
  output logic [ADDR_W-1:0]  cmd_addr,
  output logic [LEN_W-1:0]   cmd_len,
  output logic               error
);

  arb_state_e        state;
  cmd_op_e           grant;
  logic [ADDR_W-1:0] addr_aligned;
  logic              grant_done;

  // Low byte-offset bits cleared
  assign addr_aligned = {user_addr[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};

  // Completion from the engine holding the grant
  assign grant_done = (grant == OP_READ) ? rd_done : wr_done;

  // --------------------------------------------------
  // Grant FSM
  // --------------------------------------------------
  always_ff @(posedge ACLK) begin
    if (!aresetn_rrr) begin
      state      <= ARB_IDLE;
      grant      <= OP_READ;
      rd_start   <= 1'b0;
      wr_start   <= 1'b0;
      user_ready <= 1'b0;
    end else begin
      // Start and ready are single-cycle pulses
      rd_start   <= 1'b0;
      wr_start   <= 1'b0;
      user_ready <= 1'b0;
      case (state)
        ARB_IDLE: begin
          // Read wins when both enables are up
          if (user_read_enable) begin
            grant    <= OP_READ;
            rd_start <= 1'b1;
            state    <= ARB_BUSY;
          end else if (user_write_enable) begin
            grant    <= OP_WRITE;
            wr_start <= 1'b1;
            state    <= ARB_BUSY;
          end
        end
        ARB_BUSY: begin
          if (grant_done) begin
            user_ready <= 1'b1;
            state      <= ARB_DONE;
          end
        end
        // User drops its enable here
        ARB_DONE: state <= ARB_IDLE;
        default:  state <= ARB_IDLE;
      endcase
    end
  end

  // Command payload, captured on accept
  always_ff @(posedge ACLK) begin
    if (state == ARB_IDLE && (user_read_enable || user_write_enable)) begin
      cmd_addr <= addr_aligned;
      cmd_len  <= LEN_W'(user_word_size - COUNT_W'(1));
    end
  end

  // Sticky until reset
  always_ff @(posedge ACLK) begin
    if (!aresetn_rrr) begin
      error <= 1'b0;
    end else if (rd_resp_err || wr_resp_err) begin
      error <= 1'b1;
    end
  end

endmodule

//--- src/read_engine.sv
// Read burst engine
// Issues one INCR burst on AR and moves the R beats into the read FIFO

`timescale 1ns/1ps

module read_engine
  import axi_bridge_pkg::*;
#(
  parameter logic [ADDR_W-1:0] TARGET_BASE = '0
) (
  input  logic              ACLK,
  input  logic              aresetn_rrr,
  input  logic              start,
  input  logic [ADDR_W-1:0] cmd_addr,
  input  logic [LEN_W-1:0]  cmd_len,
  input  logic              m_axi_arready,
  input  logic [DATA_W-1:0] m_axi_rdata,
  input  resp_t             m_axi_rresp,
  input  logic              m_axi_rvalid,
  input  logic              rfifo_almost_full,
  output logic [ADDR_W-1:0] m_axi_araddr,
  output logic [LEN_W-1:0]  m_axi_arlen,
  output logic              m_axi_arvalid,
  output logic              m_axi_rready,
  output logic              rfifo_enq,
  output logic [DATA_W-1:0] rfifo_data,
  output logic              done,
  output logic              resp_err
);

  logic             busy;
  logic [LEN_W-1:0] beat_cnt;
  logic             r_hs;

  // Back-pressure from the read FIFO
  assign m_axi_rready = !rfifo_almost_full;
  assign r_hs         = busy && m_axi_rvalid && m_axi_rready;

  // Flagged on the beat itself
  assign resp_err = r_hs && resp_is_err(m_axi_rresp);

  always_ff @(posedge ACLK) begin
    if (!aresetn_rrr) begin
      busy          <= 1'b0;
      beat_cnt      <= '0;
      m_axi_arvalid <= 1'b0;
      rfifo_enq     <= 1'b0;
      done          <= 1'b0;
    end else begin
      rfifo_enq <= 1'b0;
      done      <= 1'b0;
      if (start) begin
        busy          <= 1'b1;
        beat_cnt      <= '0;
        m_axi_arvalid <= 1'b1;
      end else if (m_axi_arvalid && m_axi_arready) begin
        m_axi_arvalid <= 1'b0;
      end
      // Each accepted beat goes to the FIFO one cycle later
      if (r_hs) begin
        rfifo_enq <= 1'b1;
        beat_cnt  <= beat_cnt + 1'b1;
        if (beat_cnt == m_axi_arlen) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // Address, length and beat data
  always_ff @(posedge ACLK) begin
    if (start) begin
      m_axi_araddr <= TARGET_BASE + cmd_addr;
      m_axi_arlen  <= cmd_len;
    end
    if (r_hs) begin
      rfifo_data <= m_axi_rdata;
    end
  end

endmodule

//--- src/write_engine.sv
// Write burst engine
// Issues AW, streams the W beats from the write FIFO with WLAST on the
// final beat, then waits for the B response

`timescale 1ns/1ps

module write_engine
  import axi_bridge_pkg::*;
#(
  parameter logic [ADDR_W-1:0] TARGET_BASE = '0
) (
  input  logic              ACLK,
  input  logic              aresetn_rrr,
  input  logic              start,
  input  logic [ADDR_W-1:0] cmd_addr,
  input  logic [LEN_W-1:0]  cmd_len,
  input  logic              m_axi_awready,
  input  logic              m_axi_wready,
  input  resp_t             m_axi_bresp,
  input  logic              m_axi_bvalid,
  input  logic [DATA_W-1:0] wfifo_data,
  input  logic              wfifo_empty,
  output logic [ADDR_W-1:0] m_axi_awaddr,
  output logic [LEN_W-1:0]  m_axi_awlen,
  output logic              m_axi_awvalid,
  output logic [DATA_W-1:0] m_axi_wdata,
  output logic              m_axi_wlast,
  output logic              m_axi_wvalid,
  output logic              m_axi_bready,
  output logic              wfifo_deq,
  output logic              done,
  output logic              resp_err
);

  logic               busy;
  logic               addr_done;
  logic [COUNT_W-1:0] pop_cnt;
  logic               aw_hs;
  logic               addr_ok;
  logic               w_free;
  logic               words_left;
  logic               b_hs;

  // Responses always accepted
  assign m_axi_bready = 1'b1;

  // --------------------------------------------------
  // Handshake terms
  // --------------------------------------------------
  assign aw_hs = m_axi_awvalid && m_axi_awready;

  // Address accepted now or earlier
  assign addr_ok = addr_done || aw_hs;

  // W register empty or draining this cycle
  assign w_free = !m_axi_wvalid || m_axi_wready;

  // Fewer than awlen + 1 words popped so far
  assign words_left = (pop_cnt <= COUNT_W'(m_axi_awlen));

  assign wfifo_deq = busy && addr_ok && words_left && w_free && !wfifo_empty;

  assign b_hs     = busy && m_axi_bvalid && m_axi_bready;
  assign resp_err = b_hs && resp_is_err(m_axi_bresp);

  // --------------------------------------------------
  // Control
  // --------------------------------------------------
  always_ff @(posedge ACLK) begin
    if (!aresetn_rrr) begin
      busy          <= 1'b0;
      addr_done     <= 1'b0;
      pop_cnt       <= '0;
      m_axi_awvalid <= 1'b0;
      m_axi_wvalid  <= 1'b0;
      m_axi_wlast   <= 1'b0;
      done          <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy          <= 1'b1;
        addr_done     <= 1'b0;
        pop_cnt       <= '0;
        m_axi_awvalid <= 1'b1;
      end else if (aw_hs) begin
        m_axi_awvalid <= 1'b0;
        addr_done     <= 1'b1;
      end
      // Load the next beat, or drop valid once the beat is taken
      // A dry FIFO leaves WVALID low until data arrives
      if (wfifo_deq) begin
        m_axi_wvalid <= 1'b1;
        m_axi_wlast  <= (pop_cnt == COUNT_W'(m_axi_awlen));
        pop_cnt      <= pop_cnt + 1'b1;
      end else if (m_axi_wvalid && m_axi_wready) begin
        m_axi_wvalid <= 1'b0;
        m_axi_wlast  <= 1'b0;
      end
      // Burst ends on the write response
      if (b_hs) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  // Address, length and beat data
  always_ff @(posedge ACLK) begin
    if (start) begin
      m_axi_awaddr <= TARGET_BASE + cmd_addr;
      m_axi_awlen  <= cmd_len;
    end
    // Held through WREADY stalls
    if (wfifo_deq) begin
      m_axi_wdata <= wfifo_data;
    end
  end

endmodule

//--- src/axi_master_bridge.sv
// AXI4 burst master bridge top level
// User data FIFOs and command port on one side, AXI master on the other

`timescale 1ns/1ps

module axi_master_bridge
  import axi_bridge_pkg::*;
#(
  parameter int                FIFO_AW         = 4,
  parameter logic [ADDR_W-1:0] TARGET_BASE     = '0,
  parameter int                ALMOST_FULL_GAP = 3
) (
  input  logic               ACLK,
  input  logic               aresetn_rrr,
  // User data
  input  logic               user_write_enq,
  input  logic [DATA_W-1:0]  user_write_data,
  output logic               user_write_almost_full,
  input  logic               user_read_deq,
  output logic [DATA_W-1:0]  user_read_data,
  output logic               user_read_empty,
  // User command
  input  logic [ADDR_W-1:0]  user_addr,
  input  logic               user_read_enable,
  input  logic               user_write_enable,
  input  logic [COUNT_W-1:0] user_word_size,
  output logic               user_ready,
  output logic               error,
  // AXI write address and data
  output logic [ADDR_W-1:0]  m_axi_awaddr,
  output logic [LEN_W-1:0]   m_axi_awlen,
  output logic               m_axi_awvalid,
  input  logic               m_axi_awready,
  output logic [DATA_W-1:0]  m_axi_wdata,
  output logic               m_axi_wlast,
  output logic               m_axi_wvalid,
  input  logic               m_axi_wready,
  // AXI write response
  input  resp_t              m_axi_bresp,
  input  logic               m_axi_bvalid,
  output logic               m_axi_bready,
  // AXI read address and data
  output logic [ADDR_W-1:0]  m_axi_araddr,
  output logic [LEN_W-1:0]   m_axi_arlen,
  output logic               m_axi_arvalid,
  input  logic               m_axi_arready,
  input  logic [DATA_W-1:0]  m_axi_rdata,
  input  resp_t              m_axi_rresp,
  input  logic               m_axi_rvalid,
  output logic               m_axi_rready
);

  // Write FIFO to write engine
  logic              wfifo_deq;
  logic [DATA_W-1:0] wfifo_data;
  logic              wfifo_empty;
  // Read engine to read FIFO
  logic              rfifo_enq;
  logic [DATA_W-1:0] rfifo_data;
  logic              rfifo_almost_full;
  // Grant and completion
  logic              rd_start;
  logic              wr_start;
  logic [ADDR_W-1:0] cmd_addr;
  logic [LEN_W-1:0]  cmd_len;
  logic              rd_done;
  logic              wr_done;
  logic              rd_resp_err;
  logic              wr_resp_err;

  // --------------------------------------------------
  // Data FIFOs
  // --------------------------------------------------
  burst_fifo #(.FIFO_AW(FIFO_AW), .ALMOST_FULL_GAP(ALMOST_FULL_GAP)) i_write_fifo (
    .ACLK(ACLK), .aresetn_rrr(aresetn_rrr),
    .enq(user_write_enq), .data_in(user_write_data), .deq(wfifo_deq),
    .data_out(wfifo_data), .empty(wfifo_empty), .almost_full(user_write_almost_full)
  );

  burst_fifo #(.FIFO_AW(FIFO_AW), .ALMOST_FULL_GAP(ALMOST_FULL_GAP)) i_read_fifo (
    .ACLK(ACLK), .aresetn_rrr(aresetn_rrr),
    .enq(rfifo_enq), .data_in(rfifo_data), .deq(user_read_deq),
    .data_out(user_read_data), .empty(user_read_empty), .almost_full(rfifo_almost_full)
  );

  // --------------------------------------------------
  // Command arbiter and burst engines
  // --------------------------------------------------
  command_arbiter i_command_arbiter (
    .ACLK(ACLK), .aresetn_rrr(aresetn_rrr),
    .user_addr(user_addr), .user_word_size(user_word_size),
    .user_read_enable(user_read_enable), .user_write_enable(user_write_enable),
    .rd_done(rd_done), .wr_done(wr_done),
    .rd_resp_err(rd_resp_err), .wr_resp_err(wr_resp_err),
    .user_ready(user_ready), .rd_start(rd_start), .wr_start(wr_start),
    .cmd_addr(cmd_addr), .cmd_len(cmd_len), .error(error)
  );

  read_engine #(.TARGET_BASE(TARGET_BASE)) i_read_engine (
    .ACLK(ACLK), .aresetn_rrr(aresetn_rrr),
    .start(rd_start), .cmd_addr(cmd_addr), .cmd_len(cmd_len),
    .m_axi_arready(m_axi_arready), .m_axi_rdata(m_axi_rdata),
    .m_axi_rresp(m_axi_rresp), .m_axi_rvalid(m_axi_rvalid),
    .rfifo_almost_full(rfifo_almost_full),
    .m_axi_araddr(m_axi_araddr), .m_axi_arlen(m_axi_arlen),
    .m_axi_arvalid(m_axi_arvalid), .m_axi_rready(m_axi_rready),
    .rfifo_enq(rfifo_enq), .rfifo_data(rfifo_data),
    .done(rd_done), .resp_err(rd_resp_err)
  );

  write_engine #(.TARGET_BASE(TARGET_BASE)) i_write_engine (
    .ACLK(ACLK), .aresetn_rrr(aresetn_rrr),
    .start(wr_start), .cmd_addr(cmd_addr), .cmd_len(cmd_len),
    .m_axi_awready(m_axi_awready), .m_axi_wready(m_axi_wready),
    .m_axi_bresp(m_axi_bresp), .m_axi_bvalid(m_axi_bvalid),
    .wfifo_data(wfifo_data), .wfifo_empty(wfifo_empty),
    .m_axi_awaddr(m_axi_awaddr), .m_axi_awlen(m_axi_awlen),
    .m_axi_awvalid(m_axi_awvalid), .m_axi_wdata(m_axi_wdata),
    .m_axi_wlast(m_axi_wlast), .m_axi_wvalid(m_axi_wvalid),
    .m_axi_bready(m_axi_bready), .wfifo_deq(wfifo_deq),
    .done(wr_done), .resp_err(wr_resp_err)
  );

endmodule

//--- test/axi_slave_model.sv
// Behavioral AXI slave memory for the bridge testbench
// Random ready and valid stalls, one injectable response code for B and R

`timescale 1ns/1ps

module axi_slave_model
  import axi_bridge_pkg::*;
#(
  parameter int MEM_AW = 10
) (
  input  logic              ACLK,
  input  logic              aresetn_rrr,
  input  resp_t             resp_inject,
  input  logic [ADDR_W-1:0] m_axi_awaddr,
  input  logic [LEN_W-1:0]  m_axi_awlen,
  input  logic              m_axi_awvalid,
  output logic              m_axi_awready,
  input  logic [DATA_W-1:0] m_axi_wdata,
  input  logic              m_axi_wvalid,
  output logic              m_axi_wready,
  output resp_t             m_axi_bresp,
  output logic              m_axi_bvalid,
  input  logic              m_axi_bready,
  input  logic [ADDR_W-1:0] m_axi_araddr,
  input  logic [LEN_W-1:0]  m_axi_arlen,
  input  logic              m_axi_arvalid,
  output logic              m_axi_arready,
  output logic [DATA_W-1:0] m_axi_rdata,
  output resp_t             m_axi_rresp,
  output logic              m_axi_rvalid,
  input  logic              m_axi_rready
);

  logic [DATA_W-1:0] mem     [2**MEM_AW];
  logic              written [2**MEM_AW];
  logic [ADDR_W-1:0] wr_word;
  logic [ADDR_W-1:0] rd_word;
  int                wr_beat;
  int                rd_beat;
  int                wr_len;
  int                rd_len;
  logic              wr_active;
  logic              rd_active;
  logic              b_owed;
  logic              b_taken;
  logic              r_taken;

  // Unwritten words hold their word address XOR A5A50000
  function automatic logic [DATA_W-1:0] load_word(input logic [ADDR_W-1:0] word);
    if (written[MEM_AW'(word)]) begin
      return mem[MEM_AW'(word)];
    end
    return word ^ 32'hA5A5_0000;
  endfunction

  initial begin
    for (int i = 0; i < 2**MEM_AW; i++) begin
      written[i] = 1'b0;
    end
    {wr_active, rd_active, b_owed, b_taken, r_taken} = '0;
    {m_axi_awready, m_axi_wready, m_axi_arready, m_axi_bvalid, m_axi_rvalid} = '0;
    m_axi_bresp = RESP_OKAY;
    m_axi_rresp = RESP_OKAY;
    m_axi_rdata = '0;
  end

  // --------------------------------------------------
  // Handshakes, taken on the rising edge
  // --------------------------------------------------
  always @(posedge ACLK) begin
    if (!aresetn_rrr) begin
      {wr_active, rd_active, b_owed, b_taken, r_taken} = '0;
    end else begin
      if (m_axi_awvalid && m_axi_awready) begin
        wr_active = 1'b1;
        wr_word   = m_axi_awaddr >> BYTE_OFF_W;
        wr_len    = m_axi_awlen;
        wr_beat   = 0;
      end
      // Burst closes on the beat count, WLAST is checked elsewhere
      if (m_axi_wvalid && m_axi_wready) begin
        mem[MEM_AW'(wr_word + wr_beat)]     = m_axi_wdata;
        written[MEM_AW'(wr_word + wr_beat)] = 1'b1;
        if (wr_beat == wr_len) begin
          wr_active = 1'b0;
          b_owed    = 1'b1;
        end
        wr_beat++;
      end
      if (m_axi_bvalid && m_axi_bready) begin
        b_taken = 1'b1;
      end
      if (m_axi_arvalid && m_axi_arready) begin
        rd_active = 1'b1;
        rd_word   = m_axi_araddr >> BYTE_OFF_W;
        rd_len    = m_axi_arlen;
        rd_beat   = 0;
      end
      if (m_axi_rvalid && m_axi_rready) begin
        r_taken = 1'b1;
        if (rd_beat == rd_len) begin
          rd_active = 1'b0;
        end
        rd_beat++;
      end
    end
  end

  // --------------------------------------------------
  // Outputs change on the falling edge, stalls at random
  // --------------------------------------------------
  always @(negedge ACLK) begin
    m_axi_awready = !wr_active && ($urandom % 4 != 0);
    m_axi_arready = !rd_active && ($urandom % 4 != 0);
    m_axi_wready  = wr_active && ($urandom % 4 != 0);
    if (b_taken) begin
      m_axi_bvalid = 1'b0;
      b_taken      = 1'b0;
    end
    if (!m_axi_bvalid && b_owed && ($urandom % 4 != 0)) begin
      m_axi_bvalid = 1'b1;
      m_axi_bresp  = resp_inject;
      b_owed       = 1'b0;
    end
    // Next beat only once the shown one is taken
    if (r_taken) begin
      m_axi_rvalid = 1'b0;
      r_taken      = 1'b0;
    end
    if (!m_axi_rvalid && rd_active && ($urandom % 4 != 0)) begin
      m_axi_rvalid = 1'b1;
      m_axi_rdata  = load_word(rd_word + rd_beat);
      m_axi_rresp  = resp_inject;
    end
  end

endmodule

//--- test/tb_axi_master_bridge.sv
// Testbench for the AXI4 burst master bridge
// Replays commands from the vector file against a behavioral AXI slave,
// checks bus traffic, read data, user_ready and the sticky error flag

`timescale 1ns/1ps

module tb_axi_master_bridge
  import axi_bridge_pkg::*;
();

  localparam int                CLK_PERIOD  = 20;
  localparam int                NUM_VEC     = 14;
  localparam int                MODEL_AW    = 10;
  localparam logic [31:0]       SEED        = 32'h81dc;
  localparam logic [ADDR_W-1:0] TARGET_BASE = 32'h0001_0000;

  logic               ACLK;
  logic               aresetn_rrr;
  logic               user_write_enq;
  logic [DATA_W-1:0]  user_write_data;
  logic               user_write_almost_full;
  logic               user_read_deq;
  logic [DATA_W-1:0]  user_read_data;
  logic               user_read_empty;
  logic [ADDR_W-1:0]  user_addr;
  logic               user_read_enable;
  logic               user_write_enable;
  logic [COUNT_W-1:0] user_word_size;
  logic               user_ready;
  logic               error;
  logic [ADDR_W-1:0]  m_axi_awaddr;
  logic [LEN_W-1:0]   m_axi_awlen;
  logic               m_axi_awvalid;
  logic               m_axi_awready;
  logic [DATA_W-1:0]  m_axi_wdata;
  logic               m_axi_wlast;
  logic               m_axi_wvalid;
  logic               m_axi_wready;
  resp_t              m_axi_bresp;
  logic               m_axi_bvalid;
  logic               m_axi_bready;
  logic [ADDR_W-1:0]  m_axi_araddr;
  logic [LEN_W-1:0]   m_axi_arlen;
  logic               m_axi_arvalid;
  logic               m_axi_arready;
  logic [DATA_W-1:0]  m_axi_rdata;
  resp_t              m_axi_rresp;
  logic               m_axi_rvalid;
  logic               m_axi_rready;
  resp_t              resp_inject;

  // Five fields per vector: op, address, count, response, seed
  logic [31:0]        vectors [NUM_VEC*5];
  // Expected memory contents
  logic [DATA_W-1:0]  model_mem     [2**MODEL_AW];
  logic               model_written [2**MODEL_AW];
  // Bus monitor log, cleared per test
  logic [DATA_W-1:0]  w_data_q [$];
  logic               w_last_q [$];
  logic [ADDR_W-1:0]  aw_addr_seen;
  logic [LEN_W-1:0]   aw_len_seen;
  logic [ADDR_W-1:0]  ar_addr_seen;
  logic [LEN_W-1:0]   ar_len_seen;
  int                 aw_count    = 0;
  int                 ar_count    = 0;
  int                 b_count     = 0;
  int                 ready_count = 0;
  int                 b_at_ready  = 0;
  int                 err_count    = 0;
  int                 tests_passed = 0;
  int                 tests_failed = 0;
  int                 cycles       = 0;
  int                 cycle_limit  = 0;
  logic               exp_error    = 1'b0;

  axi_master_bridge #(.TARGET_BASE(TARGET_BASE)) i_axi_master_bridge (.*);

  axi_slave_model #(.MEM_AW(MODEL_AW)) i_axi_slave_model (.*);

  initial begin
    ACLK = 1'b0;
    forever #(CLK_PERIOD / 2) ACLK = ~ACLK;
  end

  // --------------------------------------------------
  // Checks and the expected memory
  // --------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      err_count++;
      $display("FAILED time=%0t signal=%s got=%h expected=%h", $time, name, actual, expected);
    end
  endtask

  task automatic report_test(input string label, input int errs_before);
    if (err_count == errs_before) begin
      tests_passed++;
      $display("%s: passed", label);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", label, err_count - errs_before);
    end
  endtask

  // Word address XOR A5A50000 until written
  function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] word);
    if (model_written[MODEL_AW'(word)]) begin
      return model_mem[MODEL_AW'(word)];
    end
    return word ^ 32'hA5A5_0000;
  endfunction

  // Bus monitor, samples on the rising edge
  always @(posedge ACLK) begin
    if (aresetn_rrr) begin
      if (m_axi_awvalid && m_axi_awready) begin
        aw_count++;
        aw_addr_seen = m_axi_awaddr;
        aw_len_seen  = m_axi_awlen;
      end
      if (m_axi_arvalid && m_axi_arready) begin
        ar_count++;
        ar_addr_seen = m_axi_araddr;
        ar_len_seen  = m_axi_arlen;
      end
      if (m_axi_wvalid && m_axi_wready) begin
        w_data_q.push_back(m_axi_wdata);
        w_last_q.push_back(m_axi_wlast);
      end
      if (m_axi_bvalid && m_axi_bready) begin
        b_count++;
      end
      if (user_ready) begin
        ready_count++;
        b_at_ready = b_count;
      end
    end
  end

  // --------------------------------------------------
  // User side drivers, all on the falling edge
  // --------------------------------------------------
  task automatic send_command(input logic is_write, input logic [31:0] addr, input int count);
    user_addr      = addr;
    user_word_size = COUNT_W'(count);
    if (is_write) begin
      user_write_enable = 1'b1;
    end else begin
      user_read_enable = 1'b1;
    end
    @(negedge ACLK);
    while (!user_ready) begin
      @(negedge ACLK);
    end
    user_read_enable  = 1'b0;
    user_write_enable = 1'b0;
  endtask

  // Random gaps, never past almost-full
  task automatic push_words(input logic [31:0] seed, input int count);
    int i;
    i = 0;
    while (i < count) begin
      @(negedge ACLK);
      if (!user_write_almost_full && ($urandom % 3 != 0)) begin
        user_write_enq  = 1'b1;
        user_write_data = seed + i;
        i++;
      end else begin
        user_write_enq = 1'b0;
      end
    end
    @(negedge ACLK);
    user_write_enq = 1'b0;
  endtask

  // Long reads pop slowly so the read FIFO fills up
  task automatic pop_words(input logic [ADDR_W-1:0] word, input int count);
    int i;
    int weight;
    i      = 0;
    weight = (count >= 64) ? 1 : 3;
    while (i < count) begin
      @(negedge ACLK);
      if (!user_read_empty && (($urandom % 4) < weight)) begin
        check_value($sformatf("user_read_data[%0d]", i), user_read_data, model_read(word + i));
        user_read_deq = 1'b1;
        i++;
      end else begin
        user_read_deq = 1'b0;
      end
    end
    @(negedge ACLK);
    user_read_deq = 1'b0;
  endtask

  // --------------------------------------------------
  // One vector: command, data, then checks
  // --------------------------------------------------
  task automatic run_vector(input int idx);
    logic [31:0]       op;
    logic [31:0]       addr;
    logic [31:0]       seed;
    int                count;
    resp_t             resp;
    logic [ADDR_W-1:0] base;
    int                errs_before;
    op          = vectors[idx*5];
    addr        = vectors[idx*5+1];
    count       = int'(vectors[idx*5+2]);
    resp        = vectors[idx*5+3][1:0];
    seed        = vectors[idx*5+4];
    errs_before = err_count;
    base        = TARGET_BASE + {addr[ADDR_W-1:2], 2'b00};
    @(negedge ACLK);
    resp_inject = resp;
    w_data_q.delete();
    w_last_q.delete();
    {aw_count, ar_count, b_count, ready_count, b_at_ready} = '0;
    if (op[0]) begin
      fork
        push_words(seed, count);
        send_command(1'b1, addr, count);
      join
      // Let the monitor see user_ready
      @(posedge ACLK);
      @(negedge ACLK);
      check_value("aw handshakes", aw_count, 1);
      check_value("m_axi_awaddr", aw_addr_seen, base);
      check_value("m_axi_awlen", aw_len_seen, count - 1);
      check_value("w beat count", w_data_q.size(), count);
      for (int i = 0; i < count && i < w_data_q.size(); i++) begin
        check_value($sformatf("m_axi_wdata[%0d]", i), w_data_q[i], seed + i);
        check_value($sformatf("m_axi_wlast[%0d]", i), w_last_q[i], i == count - 1);
      end
      check_value("b before user_ready", b_at_ready, 1);
      for (int i = 0; i < count; i++) begin
        model_mem[MODEL_AW'((base >> 2) + i)]     = seed + i;
        model_written[MODEL_AW'((base >> 2) + i)] = 1'b1;
      end
    end else begin
      fork
        pop_words(base >> 2, count);
        send_command(1'b0, addr, count);
      join
      @(posedge ACLK);
      @(negedge ACLK);
      check_value("ar handshakes", ar_count, 1);
      check_value("m_axi_araddr", ar_addr_seen, base);
      check_value("m_axi_arlen", ar_len_seen, count - 1);
      check_value("user_read_empty", user_read_empty, 1'b1);
    end
    check_value("user_ready pulses", ready_count, 1);
    // Sticky from the first error code onward
    if (resp[1]) begin
      exp_error = 1'b1;
    end
    check_value("error", error, exp_error);
    report_test($sformatf("test %0d %s addr=%h count=%0d", idx, op[0] ? "write" : "read",
                          addr, count), errs_before);
  endtask

  task automatic check_reset();
    int errs_before;
    errs_before = err_count;
    check_value("m_axi_awvalid", m_axi_awvalid, 1'b0);
    check_value("m_axi_arvalid", m_axi_arvalid, 1'b0);
    check_value("m_axi_wvalid", m_axi_wvalid, 1'b0);
    check_value("m_axi_wlast", m_axi_wlast, 1'b0);
    check_value("m_axi_bready", m_axi_bready, 1'b1);
    check_value("m_axi_rready", m_axi_rready, 1'b1);
    check_value("user_write_almost_full", user_write_almost_full, 1'b0);
    check_value("user_ready", user_ready, 1'b0);
    check_value("error", error, 1'b0);
    check_value("user_read_empty", user_read_empty, 1'b1);
    report_test("reset", errs_before);
  endtask

  // Watchdog, armed once the vectors are loaded
  initial begin
    wait (cycle_limit != 0);
    while (cycles < cycle_limit) begin
      @(posedge ACLK);
      cycles++;
    end
    $display("Timeout: the bridge did not finish within %0d cycles", cycle_limit);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    aresetn_rrr       = 1'b0;
    user_write_enq    = 1'b0;
    user_write_data   = '0;
    user_read_deq     = 1'b0;
    user_addr         = '0;
    user_read_enable  = 1'b0;
    user_write_enable = 1'b0;
    user_word_size    = '0;
    resp_inject       = RESP_OKAY;
    for (int i = 0; i < 2**MODEL_AW; i++) begin
      model_written[i] = 1'b0;
    end
    $readmemh("test/bridge_vectors.txt", vectors);
    if ($isunknown(vectors[NUM_VEC*5-1])) begin
      $display("The vector file test/bridge_vectors.txt could not be read in full");
      $display("RESULT: FAIL");
    end else begin
      cycle_limit = 200;
      for (int v = 0; v < NUM_VEC; v++) begin
        cycle_limit += int'(vectors[v*5+2]) * 8 + 50;
      end
      repeat (3) @(negedge ACLK);
      aresetn_rrr = 1'b1;
      @(negedge ACLK);
      check_reset();
      for (int v = 0; v < NUM_VEC; v++) begin
        run_vector(v);
      end
      $display("tests passed=%0d failed=%0d", tests_passed, tests_failed);
      if (tests_failed == 0 && err_count == 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
    end
    $finish;
  end

endmodule

//--- project.f
src/axi_bridge_pkg.sv
src/burst_fifo.sv
src/command_arbiter.sv
src/read_engine.sv
src/write_engine.sv
src/axi_master_bridge.sv
test/axi_slave_model.sv
test/tb_axi_master_bridge.sv

//--- test/bridge_vectors.txt
// op (0 read, 1 write)  byte address  word count  response (0 OKAY, 2 SLVERR)  data seed
// All fields hex; a write sends seed plus i on beat i, a read ignores the seed
1 00000040 004 0 11110000
0 00000040 004 0 00000000
0 00000200 008 0 00000000
1 00000103 001 0 22220000
0 00000101 003 0 00000000
1 00000300 020 0 33330000
0 00000300 020 0 00000000
0 00000400 040 0 00000000
1 00000800 100 0 44440000
0 00000800 100 0 00000000
1 00000ffc 001 0 66660000
0 00000ff0 004 0 00000000
1 00000500 010 2 55550000
0 00000040 004 0 00000000
